// ==== include/neuron_cfg.svh ====
`ifndef NEURON_CFG_SVH
`define NEURON_CFG_SVH

// Activations per input vector.
`define NEURON_INPUTS 30

// Q16.16 fixed point.
`define FRAC_BITS 16
`define DATA_WIDTH 32

// Scaled products and lane accumulators.
// Fifteen scaled products per lane stay well inside this width.
`define ACC_WIDTH 56

`endif

// ==== source/fixed_pkg.sv ====
`default_nettype none

`include "neuron_cfg.svh"

package fixed_pkg;

	typedef logic signed [`DATA_WIDTH-1:0] data_t;    // Q16.16 value.
	typedef logic signed [`ACC_WIDTH-1:0] acc_t;
	typedef logic signed [2*`DATA_WIDTH-1:0] prod_t;  // Full-width product.

	localparam data_t DATA_MAX = {1'b0, {(`DATA_WIDTH-1){1'b1}}};
	localparam data_t DATA_MIN = {1'b1, {(`DATA_WIDTH-1){1'b0}}};

	// Q16.16 times Q16.16 back to Q.16, rounding toward minus infinity.
	function automatic acc_t scale_product(data_t a, data_t b);
		prod_t full;
		prod_t shifted;
		full = prod_t'(a) * prod_t'(b);
		shifted = full >>> `FRAC_BITS;
		return shifted[`ACC_WIDTH-1:0];
	endfunction

	// Clamp to the signed data range.
	function automatic data_t saturate(acc_t value);
		if (value > acc_t'(DATA_MAX))
			return DATA_MAX;
		else if (value < acc_t'(DATA_MIN))
			return DATA_MIN;
		else
			return value[`DATA_WIDTH-1:0];
	endfunction

endpackage

`default_nettype wire

// ==== source/neuron_pkg.sv ====
`default_nettype none

`include "neuron_cfg.svh"

package neuron_pkg;

	typedef logic [$clog2(`NEURON_INPUTS)-1:0] index_t;

	// Lane chosen by the low bit of the index.
	typedef enum logic
	{
		LANE_EVEN = 1'b0,
		LANE_ODD = 1'b1
	} lane_t;

	localparam index_t LAST_INDEX = index_t'(`NEURON_INPUTS - 1);

	// Constant Q16.16 weights, one per input position.
	localparam fixed_pkg::data_t WEIGHT_TABLE [`NEURON_INPUTS] = '{
		32'h0000_C000, 32'hFFFF_6000, 32'h0001_2000, 32'hFFFF_E000, 32'h0000_4000,
		32'hFFFE_C000, 32'h0000_9999, 32'hFFFF_3333, 32'h0001_8000, 32'hFFFF_A000,
		32'h0000_2000, 32'hFFFF_0000, 32'h0000_E000, 32'hFFFF_C000, 32'h0000_6666,
		32'hFFFE_8000, 32'h0001_0000, 32'hFFFF_8CCD, 32'h0000_3333, 32'hFFFF_D000,
		32'h0000_A000, 32'hFFFF_4000, 32'h0002_0000, 32'hFFFF_F000, 32'h0000_5000,
		32'hFFFF_2000, 32'h0000_1000, 32'hFFFF_9000, 32'h0000_8000, 32'hFFFF_B000
	};

	function automatic fixed_pkg::data_t weight_of(index_t index);
		if (index > LAST_INDEX)
			return '0;  // Unused codes.
		else
			return WEIGHT_TABLE[index];
	endfunction

endpackage

`default_nettype wire

// ==== source/input_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_steer
(
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  fixed_pkg::data_t  in_data,
	output logic              even_valid,
	output logic              odd_valid,
	output fixed_pkg::data_t  lane_data,
	output fixed_pkg::data_t  lane_weight,
	output logic              flush
);

	logic               sample_valid;
	fixed_pkg::data_t   sample_data;
	neuron_pkg::index_t index;        // Position of the sampled activation.
	neuron_pkg::lane_t  lane;
	logic               last;

	// Input sample register.
	always_ff @(posedge clk)
	begin
		if (reset)
			sample_valid <= 1'b0;
		else
			sample_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
			sample_data <= in_data;
	end

	assign last = (index == neuron_pkg::LAST_INDEX);

	// Advance once the sampled activation has gone out to a lane.
	always_ff @(posedge clk)
	begin
		if (reset)
			index <= '0;
		else if (sample_valid)
		begin
			if (last)
				index <= '0;  // Next vector.
			else
				index <= index + 1'b1;
		end
	end

	assign lane = neuron_pkg::lane_t'(index[0]);

	always_comb
	begin
		even_valid = sample_valid && (lane == neuron_pkg::LANE_EVEN);
		odd_valid = sample_valid && (lane == neuron_pkg::LANE_ODD);
		lane_data = sample_data;
		lane_weight = neuron_pkg::weight_of(index);
		flush = sample_valid && last;  // Goes to both lanes.
	end

endmodule

`default_nettype wire

// ==== source/mac_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_lane
(
	input  logic              clk,
	input  logic              reset,
	input  logic              lane_valid,
	input  logic              flush,
	input  fixed_pkg::data_t  lane_data,
	input  fixed_pkg::data_t  lane_weight,
	output logic              partial_valid,
	output fixed_pkg::acc_t   partial_sum
);

	// Stage one.
	logic            stage_valid;
	logic            stage_flush;
	fixed_pkg::acc_t stage_product;

	// Stage two.
	fixed_pkg::acc_t acc;
	fixed_pkg::acc_t total;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stage_valid <= 1'b0;
			stage_flush <= 1'b0;
		end
		else
		begin
			stage_valid <= lane_valid;
			stage_flush <= flush;
		end
	end

	always_ff @(posedge clk)
	begin
		if (lane_valid)
			stage_product <= fixed_pkg::scale_product(lane_data, lane_weight);
	end

	// A flush may arrive with no product behind it.
	always_comb
	begin
		if (stage_valid)
			total = acc + stage_product;
		else
			total = acc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			partial_valid <= 1'b0;
		end
		else
		begin
			partial_valid <= stage_flush;
			if (stage_flush)
				acc <= '0;  // Start of the next vector.
			else
				acc <= total;
		end
	end

	always_ff @(posedge clk)
	begin
		if (stage_flush)
			partial_sum <= total;
	end

endmodule

`default_nettype wire

// ==== source/relu_combine.sv ====
`timescale 1ns/1ps
`default_nettype none

module relu_combine
(
	input  logic              clk,
	input  logic              reset,
	input  logic              even_valid,
	input  fixed_pkg::acc_t   even_sum,
	input  logic              odd_valid,
	input  fixed_pkg::acc_t   odd_sum,
	output logic              out_valid,
	output fixed_pkg::data_t  out_data
);

	fixed_pkg::acc_t  total;
	fixed_pkg::data_t clamped;
	fixed_pkg::data_t rectified;

	// Both lanes finish on the same edge, so even_valid qualifies the pair.
	always_comb
	begin
		total = even_sum + odd_sum;
		clamped = fixed_pkg::saturate(total);
		if (clamped[$bits(fixed_pkg::data_t)-1])
			rectified = '0;  // Negative sums become zero.
		else
			rectified = clamped;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= even_valid;
	end

	always_ff @(posedge clk)
	begin
		if (even_valid)
			out_data <= rectified;
	end

endmodule

`default_nettype wire

// ==== source/neuron_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuron_top
(
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  fixed_pkg::data_t  in_data,
	output logic              out_valid,
	output fixed_pkg::data_t  out_data
);

	logic             even_valid;
	logic             odd_valid;
	fixed_pkg::data_t lane_data;
	fixed_pkg::data_t lane_weight;
	logic             flush;

	logic             partial_valid_even;
	logic             partial_valid_odd;
	fixed_pkg::acc_t  partial_sum_even;
	fixed_pkg::acc_t  partial_sum_odd;

	input_steer steer_i
	(
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.even_valid  (even_valid),
		.odd_valid   (odd_valid),
		.lane_data   (lane_data),
		.lane_weight (lane_weight),
		.flush       (flush)
	);

	mac_lane lane_even_i
	(
		.clk           (clk),
		.reset         (reset),
		.lane_valid    (even_valid),
		.flush         (flush),
		.lane_data     (lane_data),
		.lane_weight   (lane_weight),
		.partial_valid (partial_valid_even),
		.partial_sum   (partial_sum_even)
	);

	mac_lane lane_odd_i
	(
		.clk           (clk),
		.reset         (reset),
		.lane_valid    (odd_valid),
		.flush         (flush),
		.lane_data     (lane_data),
		.lane_weight   (lane_weight),
		.partial_valid (partial_valid_odd),
		.partial_sum   (partial_sum_odd)
	);

	relu_combine combine_i
	(
		.clk        (clk),
		.reset      (reset),
		.even_valid (partial_valid_even),
		.even_sum   (partial_sum_even),
		.odd_valid  (partial_valid_odd),
		.odd_sum    (partial_sum_odd),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

// ==== verif/neuron_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuron_props
(
	input logic              clk,
	input logic              reset,
	input logic              partial_valid_even,
	input logic              partial_valid_odd,
	input logic              out_valid,
	input fixed_pkg::data_t  out_data
);

	int failure_count = 0;  // Read by the testbench at the end.

	// Both lanes are flushed on the same edge.
	lanes_agree: assert property (@(posedge clk) disable iff (reset)
		partial_valid_even == partial_valid_odd)
	else
	begin
		$error("Lane partial valids differ");
		failure_count = failure_count + 1;
	end

	out_follows_partial: assert property (@(posedge clk) disable iff (reset)
		out_valid == $past(partial_valid_even))
	else
	begin
		$error("out_valid does not follow partial_valid by one cycle");
		failure_count = failure_count + 1;
	end

	// Rectified output.
	out_non_negative: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> !out_data[$bits(fixed_pkg::data_t)-1])
	else
	begin
		$error("out_data is negative with out_valid high");
		failure_count = failure_count + 1;
	end

endmodule

`default_nettype wire

// ==== verif/neuron_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neuron_cfg.svh"

module neuron_tb;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int LATENCY = 3;

	typedef fixed_pkg::data_t vector_t [`NEURON_INPUTS];

	logic             clk;
	logic             reset;
	logic             in_valid;
	fixed_pkg::data_t in_data;
	logic             out_valid;
	fixed_pkg::data_t out_data;

	integer seed;
	int     cycle_count = 0;
	int     error_count;
	int     check_count;
	int     timeout_count;

	fixed_pkg::data_t expected_q [$];
	int               strobe_cycle_q [$];  // Edge that sampled the last strobe.

	neuron_top dut_i
	(
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	bind neuron_top neuron_props props_i
	(
		.clk                (clk),
		.reset              (reset),
		.partial_valid_even (partial_valid_even),
		.partial_valid_odd  (partial_valid_odd),
		.out_valid          (out_valid),
		.out_data           (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Weighted sum at full width, then clamp and rectify.
	function automatic fixed_pkg::data_t expected_output(vector_t acts);
		fixed_pkg::acc_t  sum;
		fixed_pkg::data_t clamped;
		sum = '0;
		for (int i = 0; i < `NEURON_INPUTS; i++)
			sum = sum + fixed_pkg::scale_product(acts[i],
				neuron_pkg::weight_of(neuron_pkg::index_t'(i)));
		clamped = fixed_pkg::saturate(sum);
		if (clamped < 0)
			return '0;
		else
			return clamped;
	endfunction

	task automatic check_data(fixed_pkg::data_t actual, fixed_pkg::data_t expected,
		string name);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_latency(int actual, int expected, string name);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR %0t %s got %0d expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic check_valid(logic actual, logic expected, string name);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR %0t %s got %b expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic idle_cycle();
		in_valid = 1'b0;
		@(posedge clk);
		#1;
	endtask

	// Small values of either sign, about +-8.0.
	function automatic void random_small(output vector_t acts);
		for (int i = 0; i < `NEURON_INPUTS; i++)
			acts[i] = fixed_pkg::data_t'($random(seed)) >>> 12;
	endfunction

	// Each activation opposes its weight's sign.
	function automatic void negative_sum(output vector_t acts);
		fixed_pkg::data_t mag;
		fixed_pkg::data_t w;
		for (int i = 0; i < `NEURON_INPUTS; i++)
		begin
			w = neuron_pkg::weight_of(neuron_pkg::index_t'(i));
			mag = $random(seed);
			mag = (mag & 32'h0003_FFFF) + 32'h0000_1000;
			acts[i] = w[31] ? mag : -mag;
		end
	endfunction

	function automatic void saturating_sum(output vector_t acts);
		fixed_pkg::data_t w;
		for (int i = 0; i < `NEURON_INPUTS; i++)
		begin
			w = neuron_pkg::weight_of(neuron_pkg::index_t'(i));
			acts[i] = w[31] ? 32'h8001_0000 : 32'h7FFF_0000;
		end
	endfunction

	task automatic send_vector(vector_t acts, int max_gap);
		fixed_pkg::data_t expected;
		int               gap;
		expected = expected_output(acts);
		for (int i = 0; i < `NEURON_INPUTS; i++)
		begin
			if (i > 0 && max_gap > 0)
			begin
				gap = $unsigned($random(seed)) % (max_gap + 1);
				repeat (gap) idle_cycle();
			end
			in_valid = 1'b1;
			in_data = acts[i];
			if (i == `NEURON_INPUTS - 1)
			begin
				expected_q.push_back(expected);
				strobe_cycle_q.push_back(cycle_count + 1);
			end
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < TIMEOUT_CYCLES)
		begin
			idle_cycle();
			waited++;
		end
		if (expected_q.size() != 0)
		begin
			$display("Timeout: %0d results still missing after %0d cycles",
				expected_q.size(), waited);
			timeout_count++;
			error_count++;
			expected_q.delete();
			strobe_cycle_q.delete();
		end
	endtask

	// Compare process.
	initial
	begin
		fixed_pkg::data_t expected;
		int               strobe_cycle;
		forever
		begin
			@(negedge clk);
			if (out_valid === 1'b1)
			begin
				if (expected_q.size() == 0)
				begin
					error_count++;
					$display("Unexpected result at %0t with no vector outstanding", $time);
				end
				else
				begin
					expected = expected_q.pop_front();
					strobe_cycle = strobe_cycle_q.pop_front();
					check_data(out_data, expected, "out_data");
					check_latency(cycle_count - strobe_cycle, LATENCY, "out_valid latency");
				end
			end
		end
	end

	initial
	begin
		vector_t acts;
		seed = 32'hea39_17e7;
		error_count = 0;
		check_count = 0;
		timeout_count = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;

		for (int i = 0; i < 5; i++)
		begin
			@(posedge clk);
			#1;
			check_valid(out_valid, 1'b0, "out_valid");
		end
		reset = 1'b0;
		repeat (8)
		begin
			idle_cycle();
			check_valid(out_valid, 1'b0, "out_valid");
		end

		repeat (4)
		begin
			random_small(acts);
			send_vector(acts, 0);
		end
		drain_results();

		repeat (4)
		begin
			negative_sum(acts);
			if (expected_output(acts) !== '0)
			begin
				error_count++;
				$display("Rectification vector does not produce a zero result");
			end
			send_vector(acts, 0);
		end
		drain_results();

		saturating_sum(acts);
		if (expected_output(acts) !== fixed_pkg::DATA_MAX)
		begin
			error_count++;
			$display("Saturation vector does not reach the positive limit");
		end
		send_vector(acts, 0);
		drain_results();

		// Random gaps inside a vector, none between vectors.
		repeat (20)
		begin
			random_small(acts);
			send_vector(acts, 3);
		end
		drain_results();
		repeat (10) idle_cycle();

		error_count += dut_i.props_i.failure_count;
		$display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			check_count, error_count, timeout_count, dut_i.props_i.failure_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== neuron_top.f ====
+incdir+include
source/fixed_pkg.sv
source/neuron_pkg.sv
source/input_steer.sv
source/mac_lane.sv
source/relu_combine.sv
source/neuron_top.sv
verif/neuron_props.sv
verif/neuron_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module neuron_tb -f neuron_top.f

# The simulation status is decided by the pass message below.
output=$(./obj_dir/Vneuron_tb +verilator+error+limit+100 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF 'All tests passed!'; then
	exit 0
else
	exit 1
fi
